// File: hw/vec_mod_config.svh
// Width and latency macros for the vector modular unit, included by RTL and testbench
`ifndef VEC_MOD_CONFIG_SVH
`define VEC_MOD_CONFIG_SVH

////////////////////
// Datapath
////////////////////

// Element and modulus width
`define VM_DATA_SIZE 32

// Vector length and element index width
`define VM_CONTROL_SIZE 8

////////////////////
// Timing
////////////////////

// Cycles from reducer go to done, one load plus one step per dividend bit
`define VM_REM_LATENCY (`VM_DATA_SIZE + 2)

`endif

// File: hw/mod_data_pkg.sv
// Arithmetic types shared by the engines, the arbiter and the remainder unit
`include "vec_mod_config.svh"

package mod_data_pkg;

  ////////////////////
  // Data words
  ////////////////////

  // One element or modulus
  typedef logic [`VM_DATA_SIZE-1:0] data_t;

  ////////////////////
  // Reducer traffic
  ////////////////////

  // Request to the remainder unit
  // Dividend keeps one extra bit so a sum with carry fits
  typedef struct packed {
    logic [`VM_DATA_SIZE:0] dividend;
    data_t                  modulus;
  } rem_req_t;

  // Result from the remainder unit
  typedef struct packed {
    data_t remainder;
  } rem_rsp_t;

endpackage

// File: hw/mod_ctrl_pkg.sv
// Control types for the engine FSMs and for ownership of the shared remainder unit
package mod_ctrl_pkg;

  ////////////////////
  // Engine FSM
  ////////////////////

  // IDLE waits for start, INPUT takes one element, WAIT holds it in the reducer
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    INPUT = 2'd1,
    WAIT  = 2'd2
  } vec_state_t;

  ////////////////////
  // Reducer owner
  ////////////////////

  // Which engine holds the remainder unit
  typedef enum logic {
    REDUCE_ENG = 1'b0,
    ADD_ENG    = 1'b1
  } req_id_t;

endpackage

// File: hw/scalar_remainder.sv
// Restoring shift-subtract remainder unit, one request per go, result after fixed latency
`include "vec_mod_config.svh"

module scalar_remainder (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   go,
  input  mod_data_pkg::rem_req_t req,
  output logic                   busy,
  output logic                   done,
  output mod_data_pkg::rem_rsp_t rsp
);

  localparam int CNT_W = $clog2(`VM_REM_LATENCY);
  // Index of the final restoring step, one step per dividend bit
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`VM_REM_LATENCY - 2);
  localparam logic [CNT_W-1:0] CNT_ONE = CNT_W'(1);

  logic                   running;
  logic [CNT_W-1:0]       count;
  logic [`VM_DATA_SIZE:0] dvd_q;
  mod_data_pkg::data_t    mod_q;
  mod_data_pkg::data_t    rem_q;
  logic [`VM_DATA_SIZE:0] trial;
  logic [`VM_DATA_SIZE:0] diff;
  mod_data_pkg::data_t    rem_next;

  ////////////////////
  // Restoring step
  ////////////////////

  // Shift next dividend bit into the partial remainder
  assign trial = {rem_q, dvd_q[`VM_DATA_SIZE]};
  assign diff = trial - {1'b0, mod_q};
  // Subtract only when trial >= modulus, result always below modulus
  assign rem_next = (trial >= {1'b0, mod_q}) ? diff[`VM_DATA_SIZE-1:0]
                                             : trial[`VM_DATA_SIZE-1:0];

  // Busy through the done cycle
  assign busy = running | done;
  assign rsp.remainder = rem_q;

  ////////////////////
  // Sequencing
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      running <= 1'b0;
      done    <= 1'b0;
      count   <= '0;
    end else begin
      done <= 1'b0;
      if (go && !busy) begin
        running <= 1'b1;
        count   <= '0;
      end else if (running) begin
        count <= count + CNT_ONE;
        // Last bit consumed, present result next cycle
        if (count == LAST_STEP) begin
          running <= 1'b0;
          done    <= 1'b1;
        end
      end
    end
  end

  // Operand and partial remainder registers
  always_ff @(posedge CLK) begin
    if (go && !busy) begin
      dvd_q <= req.dividend;
      mod_q <= req.modulus;
      rem_q <= '0;
    end else if (running) begin
      dvd_q <= {dvd_q[`VM_DATA_SIZE-1:0], 1'b0};
      rem_q <= rem_next;
    end
  end

endmodule

// File: hw/remainder_arbiter.sv
// Round-robin arbiter sharing one remainder unit between the reduce and add engines
module remainder_arbiter (
  input  logic                   CLK,
  input  logic                   RST,
  // Engine side
  input  logic                   red_req,
  input  logic                   add_req,
  input  mod_data_pkg::rem_req_t red_cmd,
  input  mod_data_pkg::rem_req_t add_cmd,
  output logic                   red_grant,
  output logic                   add_grant,
  output logic                   red_done,
  output logic                   add_done,
  output mod_data_pkg::rem_rsp_t eng_rsp,
  // Reducer side
  output logic                   go,
  output mod_data_pkg::rem_req_t rem_cmd,
  input  logic                   rem_busy,
  input  logic                   rem_done,
  input  mod_data_pkg::rem_rsp_t rem_rsp
);

  mod_ctrl_pkg::req_id_t prio;
  mod_ctrl_pkg::req_id_t owner;
  mod_ctrl_pkg::req_id_t winner;
  // Go issued, done not yet seen
  logic                  pending;
  logic                  issue;

  // Add wins when alone or when it holds priority
  assign winner = (add_req && (!red_req || prio == mod_ctrl_pkg::ADD_ENG))
                  ? mod_ctrl_pkg::ADD_ENG : mod_ctrl_pkg::REDUCE_ENG;
  assign issue = (red_req | add_req) & ~pending & ~rem_busy;

  ////////////////////
  // Grant and priority
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      prio      <= mod_ctrl_pkg::REDUCE_ENG;
      owner     <= mod_ctrl_pkg::REDUCE_ENG;
      pending   <= 1'b0;
      go        <= 1'b0;
      red_grant <= 1'b0;
      add_grant <= 1'b0;
    end else begin
      go        <= issue;
      red_grant <= issue & (winner == mod_ctrl_pkg::REDUCE_ENG);
      add_grant <= issue & (winner == mod_ctrl_pkg::ADD_ENG);
      if (issue) begin
        owner   <= winner;
        pending <= 1'b1;
        // Other engine goes first next time
        prio    <= (winner == mod_ctrl_pkg::REDUCE_ENG) ? mod_ctrl_pkg::ADD_ENG
                                                        : mod_ctrl_pkg::REDUCE_ENG;
      end else if (rem_done) begin
        pending <= 1'b0;
      end
    end
  end

  ////////////////////
  // Routing
  ////////////////////

  // Owner's command stays stable while it waits
  assign rem_cmd = (owner == mod_ctrl_pkg::ADD_ENG) ? add_cmd : red_cmd;
  assign red_done = rem_done & (owner == mod_ctrl_pkg::REDUCE_ENG);
  assign add_done = rem_done & (owner == mod_ctrl_pkg::ADD_ENG);
  assign eng_rsp = rem_rsp;

endmodule

// File: hw/vector_modular_reduce.sv
// Vector engine returning each streamed element mod the modulus via the shared reducer
`include "vec_mod_config.svh"

module vector_modular_reduce (
  input  logic                        CLK,
  input  logic                        RST,
  // Control
  input  logic                        start,
  output logic                        ready,
  input  logic                        in_enable,
  output logic                        in_ready,
  output logic                        out_enable,
  // Data
  input  logic [`VM_CONTROL_SIZE-1:0] size,
  input  mod_data_pkg::data_t         modulus,
  input  mod_data_pkg::data_t         a_in,
  output mod_data_pkg::data_t         data_out,
  // Reducer
  output logic                        rem_request,
  output mod_data_pkg::rem_req_t      rem_cmd,
  input  logic                        rem_grant,
  input  logic                        rem_done,
  input  mod_data_pkg::rem_rsp_t      rem_rsp
);

  localparam logic [`VM_CONTROL_SIZE-1:0] ONE_CONTROL = 1;

  mod_ctrl_pkg::vec_state_t    state;
  logic [`VM_CONTROL_SIZE-1:0] index;
  logic [`VM_CONTROL_SIZE-1:0] size_q;
  mod_data_pkg::rem_req_t      cmd_q;
  logic                        accept;

  // One element in flight at a time
  assign in_ready = (state == mod_ctrl_pkg::INPUT);
  assign accept = in_ready & in_enable;
  assign rem_cmd = cmd_q;

  ////////////////////
  // Control FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state       <= mod_ctrl_pkg::IDLE;
      index       <= '0;
      rem_request <= 1'b0;
      out_enable  <= 1'b0;
      ready       <= 1'b0;
      data_out    <= '0;
    end else begin
      out_enable <= 1'b0;
      ready      <= 1'b0;
      case (state)
        mod_ctrl_pkg::IDLE: begin
          if (start) begin
            index <= '0;
            state <= mod_ctrl_pkg::INPUT;
          end
        end
        mod_ctrl_pkg::INPUT: begin
          if (accept) begin
            rem_request <= 1'b1;
            state       <= mod_ctrl_pkg::WAIT;
          end
        end
        mod_ctrl_pkg::WAIT: begin
          // Drop request once the arbiter takes it
          if (rem_grant) rem_request <= 1'b0;
          if (rem_done) begin
            data_out   <= rem_rsp.remainder;
            out_enable <= 1'b1;
            if (index == size_q - ONE_CONTROL) begin
              ready <= 1'b1;
              state <= mod_ctrl_pkg::IDLE;
            end else begin
              index <= index + ONE_CONTROL;
              state <= mod_ctrl_pkg::INPUT;
            end
          end
        end
        default: state <= mod_ctrl_pkg::IDLE;
      endcase
    end
  end

  // Length and modulus held for the whole vector, dividend per element
  always_ff @(posedge CLK) begin
    if (state == mod_ctrl_pkg::IDLE && start) begin
      size_q        <= size;
      cmd_q.modulus <= modulus;
    end
    if (accept) cmd_q.dividend <= {1'b0, a_in};
  end

endmodule

// File: hw/vector_modular_add.sv
// Vector engine returning (a + b) mod the modulus per element via the shared reducer
`include "vec_mod_config.svh"

module vector_modular_add (
  input  logic                        CLK,
  input  logic                        RST,
  // Control
  input  logic                        start,
  output logic                        ready,
  input  logic                        in_enable,
  output logic                        in_ready,
  output logic                        out_enable,
  // Data
  input  logic [`VM_CONTROL_SIZE-1:0] size,
  input  mod_data_pkg::data_t         modulus,
  input  mod_data_pkg::data_t         a_in,
  input  mod_data_pkg::data_t         b_in,
  output mod_data_pkg::data_t         data_out,
  // Reducer
  output logic                        rem_request,
  output mod_data_pkg::rem_req_t      rem_cmd,
  input  logic                        rem_grant,
  input  logic                        rem_done,
  input  mod_data_pkg::rem_rsp_t      rem_rsp
);

  localparam logic [`VM_CONTROL_SIZE-1:0] ONE_CONTROL = 1;

  mod_ctrl_pkg::vec_state_t    state;
  logic [`VM_CONTROL_SIZE-1:0] index;
  logic [`VM_CONTROL_SIZE-1:0] size_q;
  mod_data_pkg::rem_req_t      cmd_q;
  logic                        accept;
  // Full sum with carry
  logic [`VM_DATA_SIZE:0]      sum;

  assign in_ready = (state == mod_ctrl_pkg::INPUT);
  assign accept = in_ready & in_enable;
  assign sum = {1'b0, a_in} + {1'b0, b_in};
  assign rem_cmd = cmd_q;

  ////////////////////
  // Control FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state       <= mod_ctrl_pkg::IDLE;
      index       <= '0;
      rem_request <= 1'b0;
      out_enable  <= 1'b0;
      ready       <= 1'b0;
      data_out    <= '0;
    end else begin
      out_enable <= 1'b0;
      ready      <= 1'b0;
      case (state)
        mod_ctrl_pkg::IDLE: begin
          if (start) begin
            index <= '0;
            state <= mod_ctrl_pkg::INPUT;
          end
        end
        mod_ctrl_pkg::INPUT: begin
          if (accept) begin
            rem_request <= 1'b1;
            state       <= mod_ctrl_pkg::WAIT;
          end
        end
        mod_ctrl_pkg::WAIT: begin
          if (rem_grant) rem_request <= 1'b0;
          // Result back, last element also ends the vector
          if (rem_done) begin
            data_out   <= rem_rsp.remainder;
            out_enable <= 1'b1;
            if (index == size_q - ONE_CONTROL) begin
              ready <= 1'b1;
              state <= mod_ctrl_pkg::IDLE;
            end else begin
              index <= index + ONE_CONTROL;
              state <= mod_ctrl_pkg::INPUT;
            end
          end
        end
        default: state <= mod_ctrl_pkg::IDLE;
      endcase
    end
  end

  // Sum captured on accept so the inputs may change while waiting
  always_ff @(posedge CLK) begin
    if (state == mod_ctrl_pkg::IDLE && start) begin
      size_q        <= size;
      cmd_q.modulus <= modulus;
    end
    if (accept) cmd_q.dividend <= sum;
  end

endmodule

// File: hw/vector_modular_unit.sv
// Top of the vector modular unit, two engines sharing one arbitrated remainder unit
`include "vec_mod_config.svh"

module vector_modular_unit (
  input  logic                        CLK,
  input  logic                        RST,
  // Reduce engine
  input  logic                        red_start,
  input  logic [`VM_CONTROL_SIZE-1:0] red_size,
  input  mod_data_pkg::data_t         red_modulus,
  input  logic                        red_in_enable,
  output logic                        red_in_ready,
  input  mod_data_pkg::data_t         red_a_in,
  output logic                        red_out_enable,
  output mod_data_pkg::data_t         red_data_out,
  output logic                        red_ready,
  // Add engine
  input  logic                        add_start,
  input  logic [`VM_CONTROL_SIZE-1:0] add_size,
  input  mod_data_pkg::data_t         add_modulus,
  input  logic                        add_in_enable,
  output logic                        add_in_ready,
  input  mod_data_pkg::data_t         add_a_in,
  input  mod_data_pkg::data_t         add_b_in,
  output logic                        add_out_enable,
  output mod_data_pkg::data_t         add_data_out,
  output logic                        add_ready
);

  ////////////////////
  // Wires
  ////////////////////

  logic                   red_req;
  logic                   add_req;
  logic                   red_grant;
  logic                   add_grant;
  logic                   red_done;
  logic                   add_done;
  mod_data_pkg::rem_req_t red_cmd;
  mod_data_pkg::rem_req_t add_cmd;
  mod_data_pkg::rem_rsp_t eng_rsp;
  // Arbiter to reducer
  logic                   rem_go;
  logic                   rem_busy;
  logic                   rem_done;
  mod_data_pkg::rem_req_t rem_cmd;
  mod_data_pkg::rem_rsp_t rem_rsp;

  vector_modular_reduce reduce_inst (
    .CLK(CLK), .RST(RST),
    .start(red_start), .ready(red_ready),
    .in_enable(red_in_enable), .in_ready(red_in_ready),
    .out_enable(red_out_enable),
    .size(red_size), .modulus(red_modulus),
    .a_in(red_a_in), .data_out(red_data_out),
    .rem_request(red_req), .rem_cmd(red_cmd),
    .rem_grant(red_grant), .rem_done(red_done), .rem_rsp(eng_rsp)
  );

  vector_modular_add add_inst (
    .CLK(CLK), .RST(RST),
    .start(add_start), .ready(add_ready),
    .in_enable(add_in_enable), .in_ready(add_in_ready),
    .out_enable(add_out_enable),
    .size(add_size), .modulus(add_modulus),
    .a_in(add_a_in), .b_in(add_b_in), .data_out(add_data_out),
    .rem_request(add_req), .rem_cmd(add_cmd),
    .rem_grant(add_grant), .rem_done(add_done), .rem_rsp(eng_rsp)
  );

  // Shared response bus, done steers it to the owner
  remainder_arbiter arbiter_inst (
    .CLK(CLK), .RST(RST),
    .red_req(red_req), .add_req(add_req),
    .red_cmd(red_cmd), .add_cmd(add_cmd),
    .red_grant(red_grant), .add_grant(add_grant),
    .red_done(red_done), .add_done(add_done), .eng_rsp(eng_rsp),
    .go(rem_go), .rem_cmd(rem_cmd),
    .rem_busy(rem_busy), .rem_done(rem_done), .rem_rsp(rem_rsp)
  );

  scalar_remainder remainder_inst (
    .CLK(CLK), .RST(RST),
    .go(rem_go), .req(rem_cmd),
    .busy(rem_busy), .done(rem_done), .rsp(rem_rsp)
  );

endmodule

// File: verification/vector_modular_unit_tb.sv
// Self-checking testbench for the vector modular unit, runs a stimulus table through both engines
`include "vec_mod_config.svh"

module vector_modular_unit_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [1:0] OP_RED = 2'd0;
  localparam logic [1:0] OP_ADD = 2'd1;
  localparam logic [1:0] OP_BOTH = 2'd2;
  localparam int NUM_FIXED_ROWS = 10;
  localparam int NUM_RANDOM_ROWS = 12;
  localparam int MAX_LEN = 4;
  // Two reducer passes per element covers the other engine cutting in
  localparam int WATCHDOG_CYCLES =
    (NUM_FIXED_ROWS + NUM_RANDOM_ROWS) * MAX_LEN * 2 * `VM_REM_LATENCY + 500;

  // One stimulus row, elements indexed 0 to 3
  typedef struct packed {
    logic [1:0]                     op;
    logic                           hold;
    mod_data_pkg::data_t            modulus;
    logic [`VM_CONTROL_SIZE-1:0]    size;
    mod_data_pkg::data_t [3:0]      a;
    mod_data_pkg::data_t [3:0]      b;
  } vec_row_t;

  logic                        CLK;
  logic                        RST;
  logic                        red_start;
  logic [`VM_CONTROL_SIZE-1:0] red_size;
  mod_data_pkg::data_t         red_modulus;
  logic                        red_in_enable;
  logic                        red_in_ready;
  mod_data_pkg::data_t         red_a_in;
  logic                        red_out_enable;
  mod_data_pkg::data_t         red_data_out;
  logic                        red_ready;
  logic                        add_start;
  logic [`VM_CONTROL_SIZE-1:0] add_size;
  mod_data_pkg::data_t         add_modulus;
  logic                        add_in_enable;
  logic                        add_in_ready;
  mod_data_pkg::data_t         add_a_in;
  mod_data_pkg::data_t         add_b_in;
  logic                        add_out_enable;
  mod_data_pkg::data_t         add_data_out;
  logic                        add_ready;

  vec_row_t            rows [$];
  // Expected results and last-element flags, one pair of queues per engine
  mod_data_pkg::data_t red_exp_q [$];
  logic                red_last_q [$];
  mod_data_pkg::data_t add_exp_q [$];
  logic                add_last_q [$];
  logic                red_last;
  logic                add_last;
  integer              seed;

  vector_modular_unit vector_modular_unit_inst (.*);

  ////////////////////
  // Clock and watchdog
  ////////////////////

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Watchdog expired at %0t, results never arrived", $time);
    abort_run();
  end

  ////////////////////
  // Reference and checks
  ////////////////////

  function automatic mod_data_pkg::data_t mod_of(mod_data_pkg::data_t a,
                                                 mod_data_pkg::data_t m);
    logic [63:0] wide;
    wide = 64'(a) % 64'(m);
    return wide[`VM_DATA_SIZE-1:0];
  endfunction

  // Sum kept at 64 bits so the carry survives
  function automatic mod_data_pkg::data_t sum_mod_of(mod_data_pkg::data_t a,
                                                     mod_data_pkg::data_t b,
                                                     mod_data_pkg::data_t m);
    logic [63:0] wide;
    wide = (64'(a) + 64'(b)) % 64'(m);
    return wide[`VM_DATA_SIZE-1:0];
  endfunction

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_data(string name, mod_data_pkg::data_t exp, mod_data_pkg::data_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  // Elements listed last to first
  function automatic void add_row(logic [1:0] op, logic hold, mod_data_pkg::data_t m,
                                  logic [`VM_CONTROL_SIZE-1:0] size,
                                  mod_data_pkg::data_t [3:0] a,
                                  mod_data_pkg::data_t [3:0] b);
    vec_row_t r;
    r.op = op;
    r.hold = hold;
    r.modulus = m;
    r.size = size;
    r.a = a;
    r.b = b;
    rows.push_back(r);
  endfunction

  ////////////////////
  // Engine drivers
  ////////////////////

  task automatic run_reduce(vec_row_t r);
    int n;
    int i;
    n = int'(r.size);
    for (i = 0; i < n; i++) begin
      red_exp_q.push_back(mod_of(r.a[i], r.modulus));
      red_last_q.push_back(i == n - 1);
    end
    red_size = r.size;
    red_modulus = r.modulus;
    red_start = 1'b1;
    @(negedge CLK);
    red_start = 1'b0;
    for (i = 0; i < n; i++) begin
      while (!red_in_ready) @(negedge CLK);
      red_in_enable = 1'b1;
      red_a_in = r.a[i];
      @(negedge CLK);
      // Element in flight blocks the input
      check_bit("red_in_ready", 1'b0, red_in_ready);
      // Held enable with junk data must not start a result
      if (r.hold) red_a_in = ~r.a[i];
      else red_in_enable = 1'b0;
    end
    while (!red_ready) @(negedge CLK);
    red_in_enable = 1'b0;
  endtask

  task automatic run_add(vec_row_t r);
    int n;
    int i;
    n = int'(r.size);
    for (i = 0; i < n; i++) begin
      add_exp_q.push_back(sum_mod_of(r.a[i], r.b[i], r.modulus));
      add_last_q.push_back(i == n - 1);
    end
    add_size = r.size;
    add_modulus = r.modulus;
    add_start = 1'b1;
    @(negedge CLK);
    add_start = 1'b0;
    for (i = 0; i < n; i++) begin
      while (!add_in_ready) @(negedge CLK);
      add_in_enable = 1'b1;
      add_a_in = r.a[i];
      add_b_in = r.b[i];
      @(negedge CLK);
      check_bit("add_in_ready", 1'b0, add_in_ready);
      if (r.hold) begin
        add_a_in = ~r.a[i];
        add_b_in = ~r.b[i];
      end else begin
        add_in_enable = 1'b0;
      end
    end
    while (!add_ready) @(negedge CLK);
    add_in_enable = 1'b0;
  endtask

  ////////////////////
  // Result monitors
  ////////////////////

  // Results in order, ready only with the last one
  initial begin
    forever begin
      @(negedge CLK);
      if (!RST) begin
        red_last = 1'b0;
        if (red_out_enable && red_exp_q.size() == 0) begin
          $display("Reduce engine produced a result that was not expected at %0t", $time);
          abort_run();
        end else begin
          if (red_out_enable) begin
            check_data("red_data_out", red_exp_q.pop_front(), red_data_out);
            red_last = red_last_q.pop_front();
          end
          check_bit("red_ready", red_last, red_ready);
        end
      end
    end
  end

  initial begin
    forever begin
      @(negedge CLK);
      if (!RST) begin
        add_last = 1'b0;
        if (add_out_enable && add_exp_q.size() == 0) begin
          $display("Add engine produced a result that was not expected at %0t", $time);
          abort_run();
        end else begin
          if (add_out_enable) begin
            check_data("add_data_out", add_exp_q.pop_front(), add_data_out);
            add_last = add_last_q.pop_front();
          end
          check_bit("add_ready", add_last, add_ready);
        end
      end
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int k;
    int unsigned pick;
    vec_row_t r;
    RST = 1'b1;
    red_start = 1'b0;
    red_size = '0;
    red_modulus = '0;
    red_in_enable = 1'b0;
    red_a_in = '0;
    add_start = 1'b0;
    add_size = '0;
    add_modulus = '0;
    add_in_enable = 1'b0;
    add_a_in = '0;
    add_b_in = '0;
    seed = 79809;

    // Small, equal and large elements, modulus of one, full-width modulus
    add_row(OP_RED, 1'b0, 32'd7, 8'd4, {32'd6, 32'd100, 32'd7, 32'd3}, '0);
    add_row(OP_RED, 1'b0, 32'd1, 8'd3, {32'd0, 32'hFFFF_FFFF, 32'd5, 32'd0}, '0);
    add_row(OP_RED, 1'b0, 32'hFFFF_FFFF, 8'd2, {64'd0, 32'hFFFF_FFFE, 32'hFFFF_FFFF}, '0);
    // Sums that wrap past the word
    add_row(OP_ADD, 1'b0, 32'd13, 8'd4, {32'd0, 32'd12, 32'd10, 32'd5},
            {32'd0, 32'd12, 32'd3, 32'd6});
    add_row(OP_ADD, 1'b0, 32'hFFFF_FFFB, 8'd3, {32'd0, 32'd1, 32'h8000_0000, 32'hFFFF_FFFF},
            {32'd0, 32'hFFFF_FFFA, 32'h8000_0000, 32'hFFFF_FFFF});
    add_row(OP_ADD, 1'b0, 32'd1000, 8'd1, {96'd0, 32'd999}, {96'd0, 32'd2});
    // Both engines contend for the reducer
    add_row(OP_BOTH, 1'b0, 32'd97, 8'd4, {32'd500, 32'd96, 32'd97, 32'd1234},
            {32'd3, 32'd1, 32'd0, 32'hFFFF_0000});
    // Enable held through each wait
    add_row(OP_RED, 1'b1, 32'd10, 8'd3, {32'd0, 32'd29, 32'd10, 32'd123}, '0);
    add_row(OP_ADD, 1'b1, 32'd3, 8'd2, {64'd0, 32'd8, 32'd4}, {64'd0, 32'd9, 32'd4});
    add_row(OP_BOTH, 1'b1, 32'd12345, 8'd4,
            {32'hFFFF_FFFF, 32'd12345, 32'd77, 32'h8765_4321},
            {32'hFFFF_FFFF, 32'd1, 32'd12268, 32'h9ABC_DEF0});

    // Random rows, some with a small modulus
    for (k = 0; k < NUM_RANDOM_ROWS; k++) begin
      pick = $unsigned($random(seed));
      r.op = 2'(pick % 3);
      r.size = 8'((pick / 3) % 4 + 1);
      r.hold = pick[9];
      r.modulus = $random(seed);
      if (pick[10]) r.modulus = r.modulus & 32'h0000_03FF;
      if (r.modulus == 32'd0) r.modulus = 32'd1;
      r.a = {$random(seed), $random(seed), $random(seed), $random(seed)};
      r.b = {$random(seed), $random(seed), $random(seed), $random(seed)};
      rows.push_back(r);
    end

    repeat (2) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);
    // Outputs straight out of reset
    check_bit("red_in_ready", 1'b0, red_in_ready);
    check_bit("red_out_enable", 1'b0, red_out_enable);
    check_bit("red_ready", 1'b0, red_ready);
    check_data("red_data_out", '0, red_data_out);
    check_bit("add_in_ready", 1'b0, add_in_ready);
    check_bit("add_out_enable", 1'b0, add_out_enable);
    check_bit("add_ready", 1'b0, add_ready);
    check_data("add_data_out", '0, add_data_out);

    for (k = 0; k < rows.size(); k++) begin
      @(negedge CLK);
      case (rows[k].op)
        OP_RED: run_reduce(rows[k]);
        OP_ADD: run_add(rows[k]);
        default: begin
          fork
            run_reduce(rows[k]);
            run_add(rows[k]);
          join
        end
      endcase
    end

    // Let the monitors take the final pulses
    repeat (2) @(negedge CLK);
    if (red_exp_q.size() != 0 || add_exp_q.size() != 0) begin
      $display("Some expected results never appeared on their engine");
      abort_run();
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

// File: sim.f
+incdir+hw
hw/mod_data_pkg.sv
hw/mod_ctrl_pkg.sv
hw/scalar_remainder.sv
hw/remainder_arbiter.sv
hw/vector_modular_reduce.sv
hw/vector_modular_add.sv
hw/vector_modular_unit.sv
verification/vector_modular_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the vector modular unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module vector_modular_unit_tb \
  -o vector_modular_unit_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/vector_modular_unit_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
